//--- verilog.f
stage_pkg.sv
stage_if.sv
fifo_ram.sv
stage_fifo.sv
byte_packer.sv
byte_unpacker.sv
stage_top.sv
tb_clock.sv
tb_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_stage --Mdir obj_sim -o tb_stage_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_sim/tb_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with no errors" sim.log; then
	echo "Result: PASS"
	exit 0
fi
echo "Result: FAIL"
exit 1

//--- tb_stage.sv
`default_nettype none

module tb_stage
	import stage_pkg::*;
();

	// Stimulus modes for in_valid and out_ready
	localparam int in_off = 0;
	localparam int in_every = 1;
	localparam int in_rand = 2;
	localparam int rdy_low = 0;
	localparam int rdy_high = 1;
	localparam int rdy_alt = 2;
	localparam int alt_span = 64;
	localparam int n_ph = 9;

	logic clk;
	logic rst;
	logic clr;
	logic in_valid;
	logic [byte_w-1:0] in_byte;
	logic out_ready;
	logic out_valid;
	logic [byte_w-1:0] out_byte;
	logic overflow;
	logic full;
	logic empty;
	logic almost_full;
	logic almost_empty;
	logic [level_w-1:0] level;

	// Phase table
	string ph_name [n_ph];
	int ph_cycles [n_ph];
	int ph_in_mode [n_ph];
	int ph_pct [n_ph];
	int ph_ready [n_ph];
	bit ph_clr [n_ph];

	// Reference model state
	int m_cnt;
	logic m_half;
	logic [byte_w-1:0] m_hi_byte;
	logic m_hi;
	logic m_lo;
	logic m_ovf;
	logic [byte_w-1:0] exp_q [$];

	string cur_phase = "startup";
	integer seed;
	int timeout_limit = 1000000;
	int cycle_count = 0;

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	stage_top DUT (
		.clk          (clk),
		.rst          (rst),
		.clr          (clr),
		.in_valid     (in_valid),
		.in_byte      (in_byte),
		.out_ready    (out_ready),
		.out_valid    (out_valid),
		.out_byte     (out_byte),
		.overflow     (overflow),
		.full         (full),
		.empty        (empty),
		.almost_full  (almost_full),
		.almost_empty (almost_empty),
		.level        (level)
	);

	////////////////////////////////////////////////////////////
	// Reporting
	////////////////////////////////////////////////////////////

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Run stopped");
	endtask

	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			stop_with_error($sformatf("MISMATCH %s %s expected %0h actual %0h",
				cur_phase, what, expected, actual));
	endtask

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_limit)
			stop_with_error($sformatf("Timeout after %0d cycles, the run never ended",
				cycle_count));
	end

	////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////

	task automatic set_row(input int i, input string name, input int cycles,
		input int in_mode, input int pct, input int ready, input bit do_clr);
		ph_name[i] = name;
		ph_cycles[i] = cycles;
		ph_in_mode[i] = in_mode;
		ph_pct[i] = pct;
		ph_ready[i] = ready;
		ph_clr[i] = do_clr;
	endtask

	task automatic load_table();
		int total;
		set_row(0, "reset_idle", 4, in_off, 0, rdy_low, 1'b0);
		set_row(1, "stream", 60, in_every, 0, rdy_high, 1'b0);
		set_row(2, "stream_drain", 10, in_off, 0, rdy_high, 1'b0);
		set_row(3, "fill_to_full", 40, in_every, 0, rdy_low, 1'b0);
		set_row(4, "drain_after_full", 50, in_off, 0, rdy_high, 1'b0);
		set_row(5, "half_then_stop", 13, in_every, 0, rdy_low, 1'b0);
		set_row(6, "clear_mid", 21, in_every, 0, rdy_high, 1'b1);
		set_row(7, "random_mix", 400, in_rand, 60, rdy_alt, 1'b0);
		set_row(8, "final_drain", 60, in_off, 0, rdy_high, 1'b0);
		total = 0;
		for (int i = 0; i < n_ph; i++)
			total = total + ph_cycles[i];
		timeout_limit = 2 * total + 100;
	endtask

	////////////////////////////////////////////////////////////
	// Reference model stepped once per clock edge
	////////////////////////////////////////////////////////////

	task automatic model_reset();
		m_cnt = 0;
		m_half = 1'b0;
		m_hi_byte = '0;
		m_hi = 1'b0;
		m_lo = 1'b0;
		m_ovf = 1'b0;
		exp_q.delete();
	endtask

	task automatic model_step(input logic iv, input logic [byte_w-1:0] b,
		input logic rdy, input logic c);
		logic deq;
		logic done;
		logic enq;
		// Consumer starts a word when not presenting a high byte
		deq = rdy && (m_cnt != 0) && !m_hi && !c;
		done = iv && m_half && !c;
		enq = done && (m_cnt != depth);
		if (c)
			model_reset();
		else
		begin
			if (enq)
			begin
				exp_q.push_back(m_hi_byte);
				exp_q.push_back(b);
			end
			if (done && !enq)
				m_ovf = 1'b1;
			if (iv)
			begin
				if (!m_half)
					m_hi_byte = b;
				m_half = !m_half;
			end
			m_cnt = m_cnt + int'(enq) - int'(deq);
			m_lo = m_hi;
			m_hi = deq;
		end
	endtask

	function automatic int expected_level(input int cnt);
		if (cnt >= depth)
			return 3;
		return cnt >> (addr_w - level_w);
	endfunction

	task automatic check_outputs();
		logic [byte_w-1:0] want;
		check("out_valid", 32'(m_hi || m_lo), 32'(out_valid));
		if (out_valid)
		begin
			if (exp_q.size() == 0)
				stop_with_error($sformatf("Phase %s: a byte came out with none expected",
					cur_phase));
			else
			begin
				want = exp_q.pop_front();
				check("out_byte", 32'(want), 32'(out_byte));
			end
		end
		check("overflow", 32'(m_ovf), 32'(overflow));
		check("empty", 32'(m_cnt == 0), 32'(empty));
		check("almost_empty", 32'(m_cnt < almost_thresh), 32'(almost_empty));
		check("almost_full", 32'(m_cnt >= depth - almost_thresh + 1), 32'(almost_full));
		check("full", 32'(m_cnt == depth), 32'(full));
		check("level", 32'(expected_level(m_cnt)), 32'(level));
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int r;
		logic iv_v;
		logic rdy_v;
		logic clr_v;
		logic [byte_w-1:0] b_v;
		clr = 1'b0;
		in_valid = 1'b0;
		in_byte = '0;
		out_ready = 1'b0;
		seed = 32'h7cc6_edf1;
		load_table();
		model_reset();
		wait (rst === 1'b1);

		for (int p = 0; p < n_ph; p++)
		begin
			cur_phase = ph_name[p];
			for (int c = 0; c < ph_cycles[p]; c++)
			begin
				@(negedge clk);
				check_outputs();
				r = $random(seed);
				b_v = 8'($random(seed));
				case (ph_in_mode[p])
					in_every: iv_v = 1'b1;
					in_rand: iv_v = ($unsigned(r) % 100) < ph_pct[p];
					default: iv_v = 1'b0;
				endcase
				case (ph_ready[p])
					rdy_high: rdy_v = 1'b1;
					rdy_alt: rdy_v = ((c / alt_span) % 2) == 0;
					default: rdy_v = 1'b0;
				endcase
				clr_v = ph_clr[p] && (c == 0);
				// No byte offered in the clear cycle itself
				if (clr_v)
					iv_v = 1'b0;
				clr = clr_v;
				in_valid = iv_v;
				in_byte = b_v;
				out_ready = rdy_v;
				model_step(iv_v, b_v, rdy_v, clr_v);
			end
		end

		@(negedge clk);
		check_outputs();
		if (exp_q.size() != 0)
			stop_with_error($sformatf("%0d expected bytes never came out", exp_q.size()));
		else
		begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

// Free running clock and power-on reset for the testbench
module tb_clock
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Reset held low for 8 rising edges, released on a falling edge
	initial
	begin
		rst = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end

endmodule

`default_nettype wire

//--- stage_top.sv
`default_nettype none

module stage_top
	import stage_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic clr,
	input logic in_valid,
	input logic [byte_w-1:0] in_byte,
	input logic out_ready,
	output logic out_valid,
	output logic [byte_w-1:0] out_byte,
	output logic overflow,
	output logic full,
	output logic empty,
	output logic almost_full,
	output logic almost_empty,
	output logic [level_w-1:0] level
);

	stage_wr_if wr_bus ();
	stage_rd_if rd_bus ();

	////////////////////////////////////////////////////////////
	// Byte in, word FIFO, byte out
	////////////////////////////////////////////////////////////

	byte_packer u_packer (
		.clk      (clk),
		.rst      (rst),
		.clr      (clr),
		.in_valid (in_valid),
		.in_byte  (in_byte),
		.wr       (wr_bus.producer),
		.overflow (overflow)
	);

	stage_fifo u_fifo (
		.clk   (clk),
		.rst   (rst),
		.clr   (clr),
		.wr    (wr_bus.fifo),
		.rd    (rd_bus.fifo),
		.level (level)
	);

	byte_unpacker u_unpacker (
		.clk       (clk),
		.rst       (rst),
		.clr       (clr),
		.out_ready (out_ready),
		.rd        (rd_bus.consumer),
		.out_valid (out_valid),
		.out_byte  (out_byte)
	);

	// Status flags to the pins
	assign full = wr_bus.full;
	assign almost_full = wr_bus.almost_full;
	assign empty = rd_bus.empty;
	assign almost_empty = rd_bus.almost_empty;

endmodule

`default_nettype wire

//--- byte_unpacker.sv
`default_nettype none

module byte_unpacker
	import stage_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic clr,
	input logic out_ready,
	stage_rd_if.consumer rd,
	output logic out_valid,
	output logic [byte_w-1:0] out_byte
);

	logic hi_phase;
	logic lo_phase;
	logic [byte_w-1:0] lo_byte;

	// New word may start when idle or while the last low byte goes out
	assign rd.deq = out_ready && !rd.empty && !hi_phase && !clr;

	always_ff @(posedge clk)
	begin
		if (!rst || clr)
		begin
			hi_phase <= 1'b0;
			lo_phase <= 1'b0;
		end
		else
		begin
			hi_phase <= rd.deq;
			lo_phase <= hi_phase;
		end
	end

	// Keep the low half while the high half is presented
	always_ff @(posedge clk)
	begin
		if (hi_phase)
			lo_byte <= rd.data[byte_w-1:0];
	end

	////////////////////////////////////////////////////////////
	// Output byte
	////////////////////////////////////////////////////////////

	// High byte straight from the RAM register in its first cycle
	assign out_valid = hi_phase || lo_phase;
	assign out_byte = hi_phase ? rd.data[word_w-1 -: byte_w] : lo_byte;

	a_clr_idle: assert property (@(posedge clk) disable iff (!rst)
		clr |=> !out_valid);

endmodule

`default_nettype wire

//--- byte_packer.sv
`default_nettype none

module byte_packer
	import stage_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic clr,
	input logic in_valid,
	input logic [byte_w-1:0] in_byte,
	stage_wr_if.producer wr,
	output logic overflow
);

	logic [byte_w-1:0] hi_byte;
	logic half;
	logic word_done;

	// Second byte of a pair; a byte arriving with clr is dropped
	assign word_done = in_valid && half && !clr;

	// First byte is the high byte of the word
	assign wr.data = {hi_byte, in_byte};
	assign wr.enq = word_done && !wr.full;

	always_ff @(posedge clk)
	begin
		if (in_valid && !half)
			hi_byte <= in_byte;
	end

	always_ff @(posedge clk)
	begin
		if (!rst || clr)
		begin
			half <= 1'b0;
			overflow <= 1'b0;
		end
		else if (in_valid)
		begin
			half <= !half;
			// Word lost, sticky until clr
			if (half && wr.full)
				overflow <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- stage_fifo.sv
`default_nettype none

module stage_fifo
	import stage_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic clr,
	stage_wr_if.fifo wr,
	stage_rd_if.fifo rd,
	output logic [level_w-1:0] level
);

	logic [addr_w-1:0] wp;
	logic [addr_w-1:0] rp;
	logic [cnt_w-1:0] cnt;
	logic [cnt_w-1:0] cnt_next;
	logic do_enq;
	logic do_deq;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	fifo_ram u_ram (
		.clk     (clk),
		.wr_en   (do_enq),
		.wr_addr (wp),
		.wr_data (wr.data),
		.rd_en   (do_deq),
		.rd_addr (rp),
		.rd_data (rd.data)
	);

	// Guarded strobes, a stray request never moves a pointer
	assign do_enq = wr.enq && !wr.full;
	assign do_deq = rd.deq && !rd.empty;

	always_comb
	begin
		cnt_next = cnt;
		if (do_enq && !do_deq)
			cnt_next = cnt + 1'b1;
		else if (do_deq && !do_enq)
			cnt_next = cnt - 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Pointers, count and registered flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst || clr)
		begin
			wp <= '0;
			rp <= '0;
			cnt <= '0;
			wr.full <= 1'b0;
			wr.almost_full <= 1'b0;
			rd.empty <= 1'b1;
			rd.almost_empty <= 1'b1;
		end
		else
		begin
			if (do_enq)
				wp <= wp + 1'b1;
			if (do_deq)
				rp <= rp + 1'b1;
			cnt <= cnt_next;
			// Flags track the count after this edge
			wr.full <= (cnt_next == depth);
			wr.almost_full <= (cnt_next >= almost_full_at);
			rd.empty <= (cnt_next == 0);
			rd.almost_empty <= (cnt_next < almost_thresh);
		end
	end

	// Top bits of the count, pinned at 3 once full
	assign level = cnt[cnt_w-1] ? {level_w{1'b1}} : cnt[addr_w-1 -: level_w];

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Packer must look at full before it writes
	a_no_enq_full: assert property (@(posedge clk) disable iff (!rst)
		wr.enq |-> !wr.full);

	// Unpacker must look at empty before it reads
	a_no_deq_empty: assert property (@(posedge clk) disable iff (!rst)
		rd.deq |-> !rd.empty);

	a_cnt_range: assert property (@(posedge clk) disable iff (!rst)
		cnt <= cnt_w'(depth));

	a_flags_excl: assert property (@(posedge clk) disable iff (!rst)
		!(rd.empty && wr.full));

endmodule

`default_nettype wire

//--- fifo_ram.sv
`default_nettype none

module fifo_ram
	import stage_pkg::*;
(
	input logic clk,
	input logic wr_en,
	input logic [addr_w-1:0] wr_addr,
	input logic [word_w-1:0] wr_data,
	input logic rd_en,
	input logic [addr_w-1:0] rd_addr,
	output logic [word_w-1:0] rd_data
);

	logic [word_w-1:0] mem [depth];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Read port, output holds until the next read
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

//--- stage_if.sv
`default_nettype none

////////////////////////////////////////////////////////////
// Write side, packer into FIFO
////////////////////////////////////////////////////////////

interface stage_wr_if
	import stage_pkg::*;
();
	logic [word_w-1:0] data;
	logic enq;
	logic full;
	logic almost_full;

	modport producer (output data, output enq, input full, input almost_full);
	modport fifo (input data, input enq, output full, output almost_full);

endinterface

////////////////////////////////////////////////////////////
// Read side, FIFO into unpacker
////////////////////////////////////////////////////////////

// data follows deq by one cycle since the RAM read is registered
interface stage_rd_if
	import stage_pkg::*;
();
	logic [word_w-1:0] data;
	logic deq;
	logic empty;
	logic almost_empty;

	modport consumer (input data, output deq, input empty, input almost_empty);
	modport fifo (output data, input deq, output empty, output almost_empty);

endinterface

`default_nettype wire

//--- stage_pkg.sv
`default_nettype none

package stage_pkg;

	// Stream byte and packed word
	localparam int byte_w = 8;
	localparam int word_w = 2 * byte_w;

	// FIFO geometry
	localparam int addr_w = 4;
	localparam int depth = 1 << addr_w;

	// One extra bit so a full count of depth fits
	localparam int cnt_w = addr_w + 1;

	// Almost flags, below thresh and at or above depth - thresh + 1
	localparam int almost_thresh = 4;
	localparam int almost_full_at = depth - almost_thresh + 1;

	localparam int level_w = 2;

endpackage

`default_nettype wire
